// ==== hdl/mac_pkg.sv ====
package mac_pkg;

  // default array geometry
  parameter int ROWS_DEF = 2;
  parameter int COLS_DEF = 4;

  // default data widths
  parameter int X_BITS_DEF = 8;
  parameter int K_BITS_DEF = 8;
  parameter int Y_BITS_DEF = 24;

  // multiplier latency, counting the input register
  parameter int DELAY_MUL_DEF = 3;

  // per-beat accumulation opcode
  typedef enum logic [1:0] {
    MAC_ACC    = 2'd0,
    MAC_FIRST  = 2'd1,
    MAC_FINAL  = 2'd2,
    MAC_SINGLE = 2'd3
  } mac_op_e;

  // output shifter occupancy
  typedef enum logic {
    SH_EMPTY = 1'b0,
    SH_DRAIN = 1'b1
  } shift_state_e;

endpackage

// ==== hdl/acc_result_if.sv ====
`timescale 1ns/1ps

interface acc_result_if #(
  parameter int ROWS   = 2,
  parameter int COLS   = 4,
  parameter int Y_BITS = 24
);

  // finished sums, one word per element
  logic [COLS-1:0][ROWS-1:0][Y_BITS-1:0] sums;
  logic                                  sums_valid;

  // shifter side of the handshake
  logic load;
  logic empty;

  modport array (
    output sums,
    output sums_valid,
    input  load,
    input  empty
  );

  modport shifter (
    input  sums,
    input  sums_valid,
    output load,
    output empty
  );

endinterface

// ==== hdl/pe_control.sv ====
`timescale 1ns/1ps

module pe_control #(
  parameter int DELAY_MUL = 3
) (
  input  logic             clk,
  input  logic             resetn,
  input  logic             s_valid,
  input  mac_pkg::mac_op_e s_op,
  output logic             s_ready,
  output logic             en,
  output logic             mul_valid,
  output logic             start_sum,
  output logic             end_sum,
  input  logic             sums_valid,
  input  logic             empty
);
  import mac_pkg::*;

  logic                 accept;
  logic                 op_start;
  logic                 op_end;
  logic [DELAY_MUL-1:0] valid_pipe;
  logic [DELAY_MUL-1:0] start_pipe;
  logic [DELAY_MUL-1:0] end_pipe;

  // a finished set that the shifter cannot take stalls everything
  assign en      = !(sums_valid && !empty);
  assign s_ready = en;
  assign accept  = s_valid && en;

  always_comb begin
    op_start = 1'b0;
    op_end   = 1'b0;
    unique case (s_op)
      MAC_ACC: begin
        op_start = 1'b0;
        op_end   = 1'b0;
      end
      MAC_FIRST: begin
        op_start = 1'b1;
      end
      MAC_FINAL: begin
        op_end = 1'b1;
      end
      MAC_SINGLE: begin
        op_start = 1'b1;
        op_end   = 1'b1;
      end
    endcase
  end

  // delay line matched to input register plus multiplier stages
  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_pipe <= '0;
      start_pipe <= '0;
      end_pipe   <= '0;
    end else if (en) begin
      valid_pipe[0] <= accept;
      start_pipe[0] <= accept && op_start;
      end_pipe[0]   <= accept && op_end;
      for (int i = 1; i < DELAY_MUL; i++) begin
        valid_pipe[i] <= valid_pipe[i-1];
        start_pipe[i] <= start_pipe[i-1];
        end_pipe[i]   <= end_pipe[i-1];
      end
    end
  end

  assign mul_valid = valid_pipe[DELAY_MUL-1];
  assign start_sum = start_pipe[DELAY_MUL-1];
  assign end_sum   = end_pipe[DELAY_MUL-1];

endmodule

// ==== hdl/pe_array.sv ====
`timescale 1ns/1ps

module pe_array #(
  parameter int ROWS      = 2,
  parameter int COLS      = 4,
  parameter int X_BITS    = 8,
  parameter int K_BITS    = 8,
  parameter int Y_BITS    = 24,
  parameter int DELAY_MUL = 3
) (
  input  logic                           clk,
  input  logic                           resetn,
  input  logic                           en,
  input  logic [ROWS-1:0][X_BITS-1:0]    s_pixels,
  input  logic [COLS-1:0][K_BITS-1:0]    s_weights,
  input  logic                           mul_valid,
  input  logic                           start_sum,
  input  logic                           end_sum,
  acc_result_if.array                    acc
);

  localparam int M_BITS = X_BITS + K_BITS;

  logic [ROWS-1:0][X_BITS-1:0]           px_reg;
  logic [COLS-1:0][K_BITS-1:0]           wt_reg;
  logic [COLS-1:0][ROWS-1:0][M_BITS-1:0] mul_comb;
  logic [COLS-1:0][ROWS-1:0][M_BITS-1:0] mul_out;
  logic [COLS-1:0][ROWS-1:0][Y_BITS-1:0] prod_y;
  logic                                  acc_en;

  // input register, pixels shared along each row
  always_ff @(posedge clk) begin
    if (en) begin
      px_reg <= s_pixels;
      wt_reg <= s_weights;
    end
  end

  for (genvar c = 0; c < COLS; c++) begin : g_col
    for (genvar r = 0; r < ROWS; r++) begin : g_row
      assign mul_comb[c][r] = $signed(px_reg[r]) * $signed(wt_reg[c]);
      // sign extend product to accumulator width
      assign prod_y[c][r]   = Y_BITS'($signed(mul_out[c][r]));
    end
  end

  // remaining DELAY_MUL-1 multiplier stages
  if (DELAY_MUL > 1) begin : g_mul_pipe
    logic [DELAY_MUL-2:0][COLS-1:0][ROWS-1:0][M_BITS-1:0] pipe;

    always_ff @(posedge clk) begin
      if (en) begin
        pipe[0] <= mul_comb;
        for (int i = 1; i < DELAY_MUL-1; i++) begin
          pipe[i] <= pipe[i-1];
        end
      end
    end

    assign mul_out = pipe[DELAY_MUL-2];
  end else begin : g_mul_direct
    assign mul_out = mul_comb;
  end

  assign acc_en = en && mul_valid;

  // accumulators restart on start_sum, otherwise keep adding
  always_ff @(posedge clk) begin
    if (acc_en) begin
      for (int c = 0; c < COLS; c++) begin
        for (int r = 0; r < ROWS; r++) begin
          acc.sums[c][r] <= (start_sum ? '0 : acc.sums[c][r]) + prod_y[c][r];
        end
      end
    end
  end

  // a new end wins over a load in the same cycle
  always_ff @(posedge clk) begin
    if (!resetn) begin
      acc.sums_valid <= 1'b0;
    end else if (acc_en && end_sum) begin
      acc.sums_valid <= 1'b1;
    end else if (acc.load) begin
      acc.sums_valid <= 1'b0;
    end
  end

endmodule

// ==== hdl/out_shifter.sv ====
`timescale 1ns/1ps

module out_shifter #(
  parameter int ROWS   = 2,
  parameter int COLS   = 4,
  parameter int Y_BITS = 24
) (
  input  logic                        clk,
  input  logic                        resetn,
  acc_result_if.shifter               acc,
  input  logic                        m_ready,
  output logic                        m_valid,
  output logic                        m_last,
  output logic [ROWS-1:0][Y_BITS-1:0] m_data
);
  import mac_pkg::*;

  localparam int CNT_W = (COLS > 1) ? $clog2(COLS) : 1;

  shift_state_e                          state;
  logic [COLS-1:0][ROWS-1:0][Y_BITS-1:0] slots;
  logic [CNT_W-1:0]                      beat_cnt;
  logic                                  beat_done;
  logic                                  final_beat;

  assign acc.empty = (state == SH_EMPTY);
  assign acc.load  = acc.empty && acc.sums_valid;

  // top slot faces the output
  assign m_valid    = (state == SH_DRAIN);
  assign m_data     = slots[COLS-1];
  assign final_beat = (beat_cnt == CNT_W'(COLS-1));
  assign m_last     = m_valid && final_beat;
  assign beat_done  = m_valid && m_ready;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state    <= SH_EMPTY;
      beat_cnt <= '0;
    end else begin
      case (state)
        SH_EMPTY: begin
          if (acc.load) begin
            state    <= SH_DRAIN;
            beat_cnt <= '0;
          end
        end
        SH_DRAIN: begin
          if (beat_done) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (final_beat) begin
              state <= SH_EMPTY;
            end
          end
        end
        default: begin
          state <= SH_EMPTY;
        end
      endcase
    end
  end

  // capture the whole set, then move one column up per beat
  always_ff @(posedge clk) begin
    if (acc.load) begin
      slots <= acc.sums;
    end else if (beat_done) begin
      for (int c = COLS-1; c > 0; c--) begin
        slots[c] <= slots[c-1];
      end
    end
  end

endmodule

// ==== hdl/mac_engine.sv ====
`timescale 1ns/1ps

module mac_engine #(
  parameter int ROWS      = mac_pkg::ROWS_DEF,
  parameter int COLS      = mac_pkg::COLS_DEF,
  parameter int X_BITS    = mac_pkg::X_BITS_DEF,
  parameter int K_BITS    = mac_pkg::K_BITS_DEF,
  parameter int Y_BITS    = mac_pkg::Y_BITS_DEF,
  parameter int DELAY_MUL = mac_pkg::DELAY_MUL_DEF
) (
  input  logic                        clk,
  input  logic                        resetn,
  input  logic                        s_valid,
  output logic                        s_ready,
  input  mac_pkg::mac_op_e            s_op,
  input  logic [ROWS-1:0][X_BITS-1:0] s_pixels,
  input  logic [COLS-1:0][K_BITS-1:0] s_weights,
  input  logic                        m_ready,
  output logic                        m_valid,
  output logic                        m_last,
  output logic [ROWS-1:0][Y_BITS-1:0] m_data
);

  logic en;
  logic mul_valid;
  logic start_sum;
  logic end_sum;

  acc_result_if #(
    .ROWS   (ROWS),
    .COLS   (COLS),
    .Y_BITS (Y_BITS)
  ) acc ();

  pe_control #(
    .DELAY_MUL (DELAY_MUL)
  ) u_control (
    .clk        (clk),
    .resetn     (resetn),
    .s_valid    (s_valid),
    .s_op       (s_op),
    .s_ready    (s_ready),
    .en         (en),
    .mul_valid  (mul_valid),
    .start_sum  (start_sum),
    .end_sum    (end_sum),
    .sums_valid (acc.sums_valid),
    .empty      (acc.empty)
  );

  pe_array #(
    .ROWS      (ROWS),
    .COLS      (COLS),
    .X_BITS    (X_BITS),
    .K_BITS    (K_BITS),
    .Y_BITS    (Y_BITS),
    .DELAY_MUL (DELAY_MUL)
  ) u_array (
    .clk       (clk),
    .resetn    (resetn),
    .en        (en),
    .s_pixels  (s_pixels),
    .s_weights (s_weights),
    .mul_valid (mul_valid),
    .start_sum (start_sum),
    .end_sum   (end_sum),
    .acc       (acc.array)
  );

  out_shifter #(
    .ROWS   (ROWS),
    .COLS   (COLS),
    .Y_BITS (Y_BITS)
  ) u_shifter (
    .clk     (clk),
    .resetn  (resetn),
    .acc     (acc.shifter),
    .m_ready (m_ready),
    .m_valid (m_valid),
    .m_last  (m_last),
    .m_data  (m_data)
  );

endmodule

// ==== dv/mac_engine_properties.sv ====
`timescale 1ns/1ps

module mac_engine_properties #(
  parameter int ROWS   = mac_pkg::ROWS_DEF,
  parameter int Y_BITS = mac_pkg::Y_BITS_DEF
) (
  input logic                        clk,
  input logic                        resetn,
  input logic                        s_ready,
  input logic                        m_valid,
  input logic                        m_ready,
  input logic                        m_last,
  input logic [ROWS-1:0][Y_BITS-1:0] m_data,
  input mac_pkg::shift_state_e       sh_state
);
  import mac_pkg::*;

  // a waiting output beat keeps its valid and its data
  a_out_hold: assert property (@(posedge clk) disable iff (!resetn)
    m_valid && !m_ready |=> m_valid && $stable(m_data))
    else $error("output beat dropped or changed while m_ready was low");

  a_last_valid: assert property (@(posedge clk) disable iff (!resetn)
    m_last |-> m_valid)
    else $error("m_last high without m_valid");

  // input stalls only come from a busy shifter
  a_stall_drain: assert property (@(posedge clk) disable iff (!resetn)
    !s_ready |-> sh_state == SH_DRAIN)
    else $error("s_ready low while the output shifter is empty");

endmodule

bind mac_engine mac_engine_properties #(
  .ROWS   (ROWS),
  .Y_BITS (Y_BITS)
) u_props (
  .clk      (clk),
  .resetn   (resetn),
  .s_ready  (s_ready),
  .m_valid  (m_valid),
  .m_ready  (m_ready),
  .m_last   (m_last),
  .m_data   (m_data),
  .sh_state (u_shifter.state)
);

// ==== dv/mac_engine_tb.sv ====
`timescale 1ns/1ps

module mac_engine_tb;
  import mac_pkg::*;

  localparam int ROWS      = ROWS_DEF;
  localparam int COLS      = COLS_DEF;
  localparam int X_BITS    = X_BITS_DEF;
  localparam int K_BITS    = K_BITS_DEF;
  localparam int Y_BITS    = Y_BITS_DEF;
  localparam int DELAY_MUL = DELAY_MUL_DEF;
  localparam int IN_LIMIT  = 200;
  localparam int OUT_LIMIT = 2000;

  typedef logic [ROWS-1:0][X_BITS-1:0] px_t;
  typedef logic [COLS-1:0][K_BITS-1:0] wt_t;
  typedef logic [ROWS-1:0][Y_BITS-1:0] beat_t;

  logic    clk;
  logic    resetn;
  logic    s_valid;
  logic    s_ready;
  mac_op_e s_op;
  px_t     s_pixels;
  wt_t     s_weights;
  logic    m_ready;
  logic    m_valid;
  logic    m_last;
  beat_t   m_data;

  // stimulus table, one row per input beat
  string   tbl_name[$];
  mac_op_e tbl_op[$];
  px_t     tbl_px[$];
  wt_t     tbl_wt[$];
  bit      tbl_hold[$];

  // expected output beats in delivery order
  string exp_name[$];
  beat_t exp_data[$];
  bit    exp_last[$];

  integer seed = 32'h7d46_eb65;
  logic   hold_ready;
  bit     stall_seen;
  bit     prev_stalled;
  beat_t  prev_data;
  int     waited;

  mac_engine #(
    .ROWS      (ROWS),
    .COLS      (COLS),
    .X_BITS    (X_BITS),
    .K_BITS    (K_BITS),
    .Y_BITS    (Y_BITS),
    .DELAY_MUL (DELAY_MUL)
  ) uut (
    .clk       (clk),
    .resetn    (resetn),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .s_op      (s_op),
    .s_pixels  (s_pixels),
    .s_weights (s_weights),
    .m_ready   (m_ready),
    .m_valid   (m_valid),
    .m_last    (m_last),
    .m_data    (m_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_with(string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic add_row(string name, mac_op_e op, px_t px, wt_t wt, bit hold);
    tbl_name.push_back(name);
    tbl_op.push_back(op);
    tbl_px.push_back(px);
    tbl_wt.push_back(wt);
    tbl_hold.push_back(hold);
  endtask

  // one sum of len beats with random operands
  task automatic add_random_set(string name, int len, bit hold);
    mac_op_e op;
    for (int i = 0; i < len; i++) begin
      if (len == 1) begin
        op = MAC_SINGLE;
      end else if (i == 0) begin
        op = MAC_FIRST;
      end else if (i == len - 1) begin
        op = MAC_FINAL;
      end else begin
        op = MAC_ACC;
      end
      add_row(name, op, px_t'($random(seed)), wt_t'($random(seed)), hold && (i == 0));
    end
  endtask

  task automatic build_table();
    add_row("single", MAC_SINGLE, 16'h0703, 32'h01020304, 1'b0);
    add_row("single", MAC_SINGLE, 16'hfe0a, 32'hfb06f908, 1'b0);
    add_row("signed_acc", MAC_FIRST, 16'h807f, 32'h807fff01, 1'b0);
    add_row("signed_acc", MAC_ACC, 16'hf905, 32'h03fd7f80, 1'b0);
    add_row("signed_acc", MAC_FINAL, 16'h1181, 32'hc0400af6, 1'b0);
    for (int k = 0; k < 8; k++) begin
      add_random_set("random_sets", 1 + ($random(seed) & 3), 1'b0);
    end
    // m_ready goes low from the first of these beats until s_ready drops
    for (int k = 0; k < 6; k++) begin
      add_random_set("backpressure", 1, k == 0);
    end
    add_random_set("backpressure", 3, 1'b0);
  endtask

  // signed sum of pixel times weight from a start opcode to an end opcode
  task automatic build_expected();
    int    sum [COLS][ROWS];
    beat_t beat;
    for (int i = 0; i < tbl_op.size(); i++) begin
      for (int c = 0; c < COLS; c++) begin
        for (int r = 0; r < ROWS; r++) begin
          if (tbl_op[i] inside {MAC_FIRST, MAC_SINGLE}) begin
            sum[c][r] = 0;
          end
          sum[c][r] += $signed(tbl_px[i][r]) * $signed(tbl_wt[i][c]);
        end
      end
      if (tbl_op[i] inside {MAC_FINAL, MAC_SINGLE}) begin
        for (int c = COLS - 1; c >= 0; c--) begin
          for (int r = 0; r < ROWS; r++) begin
            beat[r] = Y_BITS'(sum[c][r]);
          end
          exp_name.push_back(tbl_name[i]);
          exp_data.push_back(beat);
          exp_last.push_back(c == 0);
        end
      end
    end
  endtask

  task automatic check_beat();
    string name;
    beat_t want;
    bit    want_last;
    name      = exp_name.pop_front();
    want      = exp_data.pop_front();
    want_last = exp_last.pop_front();
    assert (m_data == want)
      else stop_with($sformatf("[FAIL] %s: expected data %h, actual %h", name, want, m_data));
    assert (m_last == want_last)
      else stop_with($sformatf("[FAIL] %s: expected m_last %0b, actual %0b",
                               name, want_last, m_last));
  endtask

  // output side, drives m_ready and checks each beat before its handshake edge
  always @(negedge clk) begin
    if (resetn) begin
      if (prev_stalled) begin
        assert (m_valid && m_data == prev_data)
          else stop_with("output beat changed or vanished while m_ready was low");
      end
      assert (!m_last || m_valid) else stop_with("m_last is high without m_valid");
      assert (s_ready || m_valid) else stop_with("s_ready is low with no output pending");
      m_ready = hold_ready ? 1'b0 : (($random(seed) & 1) != 0);
      if (m_valid && m_ready) begin
        assert (exp_data.size() > 0) else stop_with("output beat arrived with none expected");
        check_beat();
      end
      prev_stalled = m_valid && !m_ready;
      prev_data    = m_data;
    end
  end

  initial begin
    resetn       = 1'b0;
    s_valid      = 1'b0;
    s_op         = MAC_ACC;
    s_pixels     = '0;
    s_weights    = '0;
    m_ready      = 1'b0;
    hold_ready   = 1'b0;
    stall_seen   = 1'b0;
    prev_stalled = 1'b0;
    prev_data    = '0;
    build_table();
    build_expected();
    repeat (2) @(posedge clk);
    @(negedge clk);
    resetn <= 1'b1;
    assert (s_ready && !m_valid && !m_last)
      else stop_with("after reset s_ready should be high and m_valid, m_last low");
    foreach (tbl_op[i]) begin
      @(negedge clk);
      if (tbl_hold[i]) begin
        hold_ready <= 1'b1;
      end
      s_valid   = 1'b1;
      s_op      = tbl_op[i];
      s_pixels  = tbl_px[i];
      s_weights = tbl_wt[i];
      waited    = 0;
      while (!s_ready) begin
        // array froze under held m_ready, so let the output drain again
        if (hold_ready) begin
          stall_seen = 1'b1;
          hold_ready <= 1'b0;
        end
        @(negedge clk);
        waited++;
        assert (waited < IN_LIMIT) else stop_with("timed out waiting for s_ready");
      end
    end
    @(negedge clk);
    s_valid = 1'b0;
    assert (stall_seen) else stop_with("s_ready never fell while m_ready was held low");
    waited = 0;
    while (exp_data.size() > 0) begin
      @(negedge clk);
      waited++;
      assert (waited < OUT_LIMIT) else stop_with("timed out waiting for expected output beats");
    end
    @(negedge clk);
    assert (!m_valid) else stop_with("extra output beat after the last expected one");
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== sources.f ====
hdl/mac_pkg.sv
hdl/acc_result_if.sv
hdl/pe_control.sv
hdl/pe_array.sv
hdl/out_shifter.sv
hdl/mac_engine.sv
dv/mac_engine_properties.sv
dv/mac_engine_tb.sv
